// ==== list.f ====
+incdir+design
design/serial_link_pkg.sv
design/serial_link_fifo.sv
design/serial_link_regs.sv
design/serial_link_phy_tx.sv
design/serial_link_phy_rx.sv
design/serial_link.sv
test/tb_serial_link.sv

// ==== test/tb_serial_link.sv ====
`include "serial_link_cfg.svh"

module tb_serial_link;

  localparam int op_write      = 0;
  localparam int op_read       = 1;
  localparam int op_write_rand = 2;
  localparam int op_wait_valid = 3;
  localparam int op_pins       = 4;
  // Cycles for the longest word at the largest divider plus slack
  localparam int word_cycles   = 4 * 255 + 20;

  logic                       clk_i;
  logic                       reset_i;
  serial_link_pkg::apb_addr_t paddr_i;
  logic                       psel_i;
  logic                       penable_i;
  logic                       pwrite_i;
  serial_link_pkg::apb_data_t pwdata_i;
  serial_link_pkg::apb_data_t prdata_o;
  logic                       pready_o;
  logic                       pslverr_o;
  logic [1:0]                 isolated_i;
  logic [1:0]                 isolate_o;
  logic                       clk_ena_o;
  logic                       link_rst_n_o;
  serial_link_pkg::lane_t     ddr_i;
  serial_link_pkg::lane_t     ddr_o;
  logic                       ddr_rcv_clk_i;
  logic                       ddr_rcv_clk_o;

  // Stimulus table with one entry per row in each queue
  int          op_q[$];
  logic [7:0]  addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] exp_q[$];
  logic        err_q[$];
  logic [1:0]  iso_q[$];

  int          errors;
  int          cur_row;
  logic        table_ready;
  logic [15:0] tx_lfsr;
  logic [15:0] exp_lfsr;

  serial_link dut (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .paddr_i       ( paddr_i       ),
    .psel_i        ( psel_i        ),
    .penable_i     ( penable_i     ),
    .pwrite_i      ( pwrite_i      ),
    .pwdata_i      ( pwdata_i      ),
    .prdata_o      ( prdata_o      ),
    .pready_o      ( pready_o      ),
    .pslverr_o     ( pslverr_o     ),
    .isolated_i    ( isolated_i    ),
    .isolate_o     ( isolate_o     ),
    .clk_ena_o     ( clk_ena_o     ),
    .link_rst_n_o  ( link_rst_n_o  ),
    .ddr_i         ( ddr_i         ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  // Loopback of the lanes and the forwarded clock
  assign ddr_i         = ddr_o;
  assign ddr_rcv_clk_i = ddr_rcv_clk_o;

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  // One step per bit taken
  task automatic draw_word(inout logic [15:0] state, output logic [15:0] word);
    word = '0;
    for (int b = 0; b < 16; b++) begin
      word  = {word[14:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h (row %0d)", name, got, exp, cur_row);
      errors++;
    end
  endtask

  task automatic add_row(input int op, input logic [7:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp, input logic exp_err, input logic [1:0] iso);
    op_q.push_back(op);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    exp_q.push_back(exp);
    err_q.push_back(exp_err);
    iso_q.push_back(iso);
  endtask

  // All APB tasks start and end 2 units after a rising edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    paddr_i   = addr;
    pwdata_i  = data;
    pwrite_i  = 1'b1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(posedge clk_i);
    #2;
    penable_i = 1'b1;
    @(negedge clk_i);
    err = pslverr_o;
    check_value("pready", {31'h0, pready_o}, 32'h1);
    @(posedge clk_i);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    paddr_i   = addr;
    pwrite_i  = 1'b0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(posedge clk_i);
    #2;
    penable_i = 1'b1;
    @(negedge clk_i);
    data = prdata_o;
    err  = pslverr_o;
    check_value("pready", {31'h0, pready_o}, 32'h1);
    @(posedge clk_i);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table contents
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    int div;
    // Pin vector is {lanes, rcv_clk, isolate, link_rst_n, clk_ena}
    // Reset values
    add_row(op_pins, 8'h00, 0, 32'h0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CTRL, 0, 32'h0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CLK_DIV, 0, 32'h1, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_RAW_OUT_CTRL, 0, 32'h0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_RAW_IN_DATA, 0, 32'h0, 1'b0, 2'b00);
    // Control and status
    add_row(op_write, `SL_REG_CTRL, 32'h303, 0, 1'b0, 2'b00);
    add_row(op_pins, 8'h00, 0, 32'h0F, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CTRL, 0, 32'h303, 1'b0, 2'b00);
    add_row(op_write, `SL_REG_CTRL, 32'h101, 0, 1'b0, 2'b00);
    add_row(op_pins, 8'h00, 0, 32'h05, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CTRL, 0, 32'h101, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_ISOLATED, 0, 32'h2, 1'b0, 2'b10);
    add_row(op_read, `SL_REG_ISOLATED, 0, 32'h1, 1'b0, 2'b01);
    add_row(op_write, `SL_REG_CLK_DIV, 32'h0, 0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CLK_DIV, 0, 32'h1, 1'b0, 2'b00);
    add_row(op_write, `SL_REG_CLK_DIV, 32'h5, 0, 1'b0, 2'b00);
    // Bad accesses leave the registers alone
    add_row(op_read, 8'h40, 0, 32'h0, 1'b1, 2'b00);
    add_row(op_write, 8'h40, 32'hFFFF_FFFF, 0, 1'b1, 2'b00);
    add_row(op_write, `SL_REG_RAW_IN_DATA, 32'hFFFF_FFFF, 0, 1'b1, 2'b00);
    add_row(op_write, `SL_REG_ISOLATED, 32'hFFFF_FFFF, 0, 1'b1, 2'b00);
    add_row(op_read, `SL_REG_CTRL, 0, 32'h101, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_CLK_DIV, 0, 32'h5, 1'b0, 2'b00);
    // TX FIFO fills while the transmitter is disabled
    for (int i = 0; i < 8; i++) begin
      add_row(op_write, `SL_REG_RAW_OUT_DATA, 32'h1000 + i, 0, 1'b0, 2'b00);
      add_row(op_read, `SL_REG_RAW_OUT_CTRL, 0, (i == 7) ? 32'h108 : i + 1, 1'b0, 2'b00);
    end
    add_row(op_write, `SL_REG_RAW_OUT_DATA, 32'h1008, 0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_RAW_OUT_CTRL, 0, 32'h108, 1'b0, 2'b00);
    add_row(op_write, `SL_REG_RAW_OUT_CTRL, 32'h8000_0000, 0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_RAW_OUT_CTRL, 0, 32'h0, 1'b0, 2'b00);
    add_row(op_read, `SL_REG_RAW_IN_DATA, 0, 32'h0, 1'b0, 2'b00);
    // Loopback at two dividers
    for (int k = 0; k < 2; k++) begin
      div = (k == 0) ? 1 : 3;
      add_row(op_write, `SL_REG_CLK_DIV, div, 0, 1'b0, 2'b00);
      add_row(op_read, `SL_REG_CLK_DIV, 0, div, 1'b0, 2'b00);
      add_row(op_write, `SL_REG_RAW_OUT_EN, 32'h1, 0, 1'b0, 2'b00);
      for (int w = 0; w < 5; w++) begin
        add_row(op_write_rand, `SL_REG_RAW_OUT_DATA, 0, 0, 1'b0, 2'b00);
      end
      for (int w = 0; w < 5; w++) begin
        add_row(op_wait_valid, `SL_REG_RAW_IN_DATA, 0, 0, 1'b0, 2'b00);
      end
      add_row(op_read, `SL_REG_RAW_IN_DATA, 0, 32'h0, 1'b0, 2'b00);
      add_row(op_pins, 8'h00, 0, 32'h05, 1'b0, 2'b00);
      add_row(op_write, `SL_REG_RAW_OUT_EN, 32'h0, 0, 1'b0, 2'b00);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Row execution
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    logic [31:0] rdata;
    logic [31:0] pins;
    logic        err;
    logic [15:0] word;
    int          polls;
    cur_row    = idx;
    isolated_i = iso_q[idx];
    case (op_q[idx])
      op_write: begin
        apb_write(addr_q[idx], wdata_q[idx], err);
        check_value("pslverr", {31'h0, err}, {31'h0, err_q[idx]});
      end
      op_read: begin
        apb_read(addr_q[idx], rdata, err);
        check_value("prdata", rdata, exp_q[idx]);
        check_value("pslverr", {31'h0, err}, {31'h0, err_q[idx]});
      end
      op_write_rand: begin
        draw_word(tx_lfsr, word);
        apb_write(addr_q[idx], {16'h0, word}, err);
        check_value("pslverr", {31'h0, err}, {31'h0, err_q[idx]});
      end
      op_wait_valid: begin
        draw_word(exp_lfsr, word);
        polls = 1;
        apb_read(addr_q[idx], rdata, err);
        while (!rdata[31] && polls < word_cycles) begin
          apb_read(addr_q[idx], rdata, err);
          polls++;
        end
        if (!rdata[31]) begin
          $display("No word arrived on RAW_IN_DATA within %0d reads (row %0d)", polls, idx);
          errors++;
        end else begin
          check_value("RAW_IN_DATA", rdata, {1'b1, 15'h0, word});
        end
      end
      default: begin
        @(negedge clk_i);
        pins = {19'h0, ddr_o, ddr_rcv_clk_o, isolate_o, link_rst_n_o, clk_ena_o};
        check_value("pins", pins, exp_q[idx]);
        @(posedge clk_i);
        #2;
      end
    endcase
  endtask

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    paddr_i     = '0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    pwdata_i    = '0;
    isolated_i  = 2'b00;
    errors      = 0;
    cur_row     = 0;
    tx_lfsr     = 16'd19662;
    exp_lfsr    = 16'd19662;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int r = 0; r < op_q.size(); r++) begin
      run_row(r);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #(op_q.size() * word_cycles * 20);
    $display("Timeout: the test did not finish in the expected time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== design/serial_link.sv ====
module serial_link (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  serial_link_pkg::apb_addr_t paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  serial_link_pkg::apb_data_t pwdata_i,
  output serial_link_pkg::apb_data_t prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  logic [1:0]                 isolated_i,
  output logic [1:0]                 isolate_o,
  output logic                       clk_ena_o,
  output logic                       link_rst_n_o,
  input  serial_link_pkg::lane_t     ddr_i,
  output serial_link_pkg::lane_t     ddr_o,
  input  logic                       ddr_rcv_clk_i,
  output logic                       ddr_rcv_clk_o
);

  serial_link_pkg::clk_div_t  clk_div;
  logic                       raw_out_en;
  logic                       tx_push;
  logic                       tx_clear;
  logic                       tx_pop;
  logic                       tx_full;
  logic                       tx_not_empty;
  serial_link_pkg::fill_t     tx_fill;
  serial_link_pkg::phy_data_t tx_wdata;
  serial_link_pkg::phy_data_t tx_head;
  logic                       rx_push;
  logic                       rx_pop;
  logic                       rx_not_empty;
  serial_link_pkg::phy_data_t rx_word;
  serial_link_pkg::phy_data_t rx_head;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  serial_link_regs i_regs (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .paddr_i        ( paddr_i      ),
    .psel_i         ( psel_i       ),
    .penable_i      ( penable_i    ),
    .pwrite_i       ( pwrite_i     ),
    .pwdata_i       ( pwdata_i     ),
    .prdata_o       ( prdata_o     ),
    .pready_o       ( pready_o     ),
    .pslverr_o      ( pslverr_o    ),
    .isolated_i     ( isolated_i   ),
    .tx_fill_i      ( tx_fill      ),
    .tx_full_i      ( tx_full      ),
    .rx_data_i      ( rx_head      ),
    .rx_not_empty_i ( rx_not_empty ),
    .clk_ena_o      ( clk_ena_o    ),
    .link_rst_n_o   ( link_rst_n_o ),
    .isolate_o      ( isolate_o    ),
    .clk_div_o      ( clk_div      ),
    .raw_out_en_o   ( raw_out_en   ),
    .tx_push_o      ( tx_push      ),
    .tx_data_o      ( tx_wdata     ),
    .tx_clear_o     ( tx_clear     ),
    .rx_pop_o       ( rx_pop       )
  );

  //////////////////////////////////////////////////////////////////////
  // Raw mode FIFOs and PHY
  //////////////////////////////////////////////////////////////////////

  serial_link_fifo i_tx_fifo (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .clear_i     ( tx_clear     ),
    .push_i      ( tx_push      ),
    .data_i      ( tx_wdata     ),
    .pop_i       ( tx_pop       ),
    .data_o      ( tx_head      ),
    .not_empty_o ( tx_not_empty ),
    .full_o      ( tx_full      ),
    .fill_o      ( tx_fill      )
  );

  // RX side has no software clear, overflow words are simply lost
  serial_link_fifo i_rx_fifo (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .clear_i     ( 1'b0         ),
    .push_i      ( rx_push      ),
    .data_i      ( rx_word      ),
    .pop_i       ( rx_pop       ),
    .data_o      ( rx_head      ),
    .not_empty_o ( rx_not_empty ),
    .full_o      (              ),
    .fill_o      (              )
  );

  serial_link_phy_tx i_phy_tx (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .clk_div_i     ( clk_div       ),
    .raw_out_en_i  ( raw_out_en    ),
    .data_i        ( tx_head       ),
    .not_empty_i   ( tx_not_empty  ),
    .pop_o         ( tx_pop        ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  serial_link_phy_rx i_phy_rx (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .ddr_i         ( ddr_i         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .data_o        ( rx_word       ),
    .valid_o       ( rx_push       )
  );

endmodule

// ==== design/serial_link_phy_rx.sv ====
module serial_link_phy_rx (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  serial_link_pkg::lane_t     ddr_i,
  input  logic                       ddr_rcv_clk_i,
  output serial_link_pkg::phy_data_t data_o,
  output logic                       valid_o
);

  serial_link_pkg::lane_t lanes_meta_q;
  serial_link_pkg::lane_t lanes_sync_q;
  serial_link_pkg::lane_t low_q;
  logic                   clk_meta_q;
  logic                   clk_sync_q;
  logic                   clk_prev_q;
  logic                   rise;
  logic                   fall;

  // Receive clock is oversampled, its edges mark the byte positions
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clk_meta_q <= 1'b0;
      clk_sync_q <= 1'b0;
      clk_prev_q <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      clk_meta_q <= ddr_rcv_clk_i;
      clk_sync_q <= clk_meta_q;
      clk_prev_q <= clk_sync_q;
      valid_o    <= fall;
    end
  end

  assign rise = clk_sync_q & ~clk_prev_q;
  assign fall = ~clk_sync_q & clk_prev_q;

  // Lanes use the same two stages, so they line up with the clock
  always_ff @(posedge clk_i) begin
    lanes_meta_q <= ddr_i;
    lanes_sync_q <= lanes_meta_q;
    if (rise) begin
      low_q <= lanes_sync_q;
    end
    if (fall) begin
      data_o <= {lanes_sync_q, low_q};
    end
  end

endmodule

// ==== design/serial_link_phy_tx.sv ====
module serial_link_phy_tx (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  serial_link_pkg::clk_div_t  clk_div_i,
  input  logic                       raw_out_en_i,
  input  serial_link_pkg::phy_data_t data_i,
  input  logic                       not_empty_i,
  output logic                       pop_o,
  output serial_link_pkg::lane_t     ddr_o,
  output logic                       ddr_rcv_clk_o
);

  localparam int unsigned LaneW = $bits(serial_link_pkg::lane_t);

  serial_link_pkg::tx_state_e  state_q;
  serial_link_pkg::tx_state_e  state_d;
  serial_link_pkg::clk_div_t   phase_cnt_q;
  serial_link_pkg::phy_data_t  word_q;
  logic                        phase_done;
  logic                        fetch;

  // Each phase lasts clk_div_i cycles
  assign phase_done = (phase_cnt_q >= clk_div_i - serial_link_pkg::clk_div_t'(1));

  // Next word is taken when idle or right at the end of the last phase
  assign fetch = raw_out_en_i & not_empty_i &
                 ((state_q == serial_link_pkg::TX_IDLE) |
                  ((state_q == serial_link_pkg::TX_HIGH_SETUP) & phase_done));
  assign pop_o = fetch;

  always_comb begin
    state_d = state_q;
    case (state_q)
      serial_link_pkg::TX_IDLE: begin
        if (fetch) state_d = serial_link_pkg::TX_LOW_SETUP;
      end
      serial_link_pkg::TX_LOW_SETUP: begin
        if (phase_done) state_d = serial_link_pkg::TX_LOW_HOLD;
      end
      serial_link_pkg::TX_LOW_HOLD: begin
        if (phase_done) state_d = serial_link_pkg::TX_HIGH_HOLD;
      end
      serial_link_pkg::TX_HIGH_HOLD: begin
        if (phase_done) state_d = serial_link_pkg::TX_HIGH_SETUP;
      end
      serial_link_pkg::TX_HIGH_SETUP: begin
        if (phase_done) begin
          state_d = fetch ? serial_link_pkg::TX_LOW_SETUP : serial_link_pkg::TX_IDLE;
        end
      end
      default: state_d = serial_link_pkg::TX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= serial_link_pkg::TX_IDLE;
      phase_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == serial_link_pkg::TX_IDLE || phase_done) begin
        phase_cnt_q <= '0;
      end else begin
        phase_cnt_q <= phase_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch) begin
      word_q <= data_i;
    end
  end

  // Lanes and forwarded clock decoded from the phase
  always_comb begin
    ddr_o         = '0;
    ddr_rcv_clk_o = 1'b0;
    case (state_q)
      serial_link_pkg::TX_LOW_SETUP: ddr_o = word_q[LaneW-1:0];
      serial_link_pkg::TX_LOW_HOLD: begin
        ddr_o         = word_q[LaneW-1:0];
        ddr_rcv_clk_o = 1'b1;
      end
      serial_link_pkg::TX_HIGH_HOLD: begin
        ddr_o         = word_q[2*LaneW-1:LaneW];
        ddr_rcv_clk_o = 1'b1;
      end
      serial_link_pkg::TX_HIGH_SETUP: ddr_o = word_q[2*LaneW-1:LaneW];
      default: ddr_o = '0;
    endcase
  end

endmodule

// ==== design/serial_link_regs.sv ====
`include "serial_link_cfg.svh"

module serial_link_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // APB slave
  input  serial_link_pkg::apb_addr_t paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  serial_link_pkg::apb_data_t pwdata_i,
  output serial_link_pkg::apb_data_t prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Status from the link
  input  logic [1:0]                 isolated_i,
  input  serial_link_pkg::fill_t     tx_fill_i,
  input  logic                       tx_full_i,
  input  serial_link_pkg::phy_data_t rx_data_i,
  input  logic                       rx_not_empty_i,
  // Control to the link
  output logic                       clk_ena_o,
  output logic                       link_rst_n_o,
  output logic [1:0]                 isolate_o,
  output serial_link_pkg::clk_div_t  clk_div_o,
  output logic                       raw_out_en_o,
  output logic                       tx_push_o,
  output serial_link_pkg::phy_data_t tx_data_o,
  output logic                       tx_clear_o,
  output logic                       rx_pop_o
);

  localparam int unsigned DataW = $bits(serial_link_pkg::phy_data_t);
  localparam int unsigned FillW = $bits(serial_link_pkg::fill_t);

  logic access;
  logic wr;
  logic rd;
  logic sel_ctrl;
  logic sel_isolated;
  logic sel_clk_div;
  logic sel_out_en;
  logic sel_out_data;
  logic sel_out_ctrl;
  logic sel_in_data;
  logic mapped;

  //////////////////////////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////////////////////////

  // No wait states, so the access phase is a single cycle
  assign access = psel_i & penable_i;
  assign wr     = access & pwrite_i;
  assign rd     = access & ~pwrite_i;

  assign sel_ctrl     = (paddr_i == `SL_REG_CTRL);
  assign sel_isolated = (paddr_i == `SL_REG_ISOLATED);
  assign sel_clk_div  = (paddr_i == `SL_REG_CLK_DIV);
  assign sel_out_en   = (paddr_i == `SL_REG_RAW_OUT_EN);
  assign sel_out_data = (paddr_i == `SL_REG_RAW_OUT_DATA);
  assign sel_out_ctrl = (paddr_i == `SL_REG_RAW_OUT_CTRL);
  assign sel_in_data  = (paddr_i == `SL_REG_RAW_IN_DATA);

  assign mapped = sel_ctrl | sel_isolated | sel_clk_div | sel_out_en |
                  sel_out_data | sel_out_ctrl | sel_in_data;

  assign pready_o  = 1'b1;
  // Status and RX data are read only
  assign pslverr_o = access & (~mapped | (pwrite_i & (sel_isolated | sel_in_data)));

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clk_ena_o    <= 1'b0;
      link_rst_n_o <= 1'b0;
      isolate_o    <= 2'b00;
      clk_div_o    <= serial_link_pkg::clk_div_t'(1);
      raw_out_en_o <= 1'b0;
    end else if (wr) begin
      if (sel_ctrl) begin
        clk_ena_o    <= pwdata_i[0];
        link_rst_n_o <= pwdata_i[1];
        isolate_o    <= pwdata_i[9:8];
      end
      // A divider of zero would stall the transmitter
      if (sel_clk_div) begin
        if (pwdata_i[`SL_CLK_DIV_W-1:0] == '0) begin
          clk_div_o <= serial_link_pkg::clk_div_t'(1);
        end else begin
          clk_div_o <= pwdata_i[`SL_CLK_DIV_W-1:0];
        end
      end
      if (sel_out_en) begin
        raw_out_en_o <= pwdata_i[0];
      end
    end
  end

  // FIFO strobes last exactly one access phase
  assign tx_push_o  = wr & sel_out_data;
  assign tx_data_o  = pwdata_i[DataW-1:0];
  assign tx_clear_o = wr & sel_out_ctrl & pwdata_i[31];
  assign rx_pop_o   = rd & sel_in_data & rx_not_empty_i;

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `SL_REG_CTRL: begin
        prdata_o[0]   = clk_ena_o;
        prdata_o[1]   = link_rst_n_o;
        prdata_o[9:8] = isolate_o;
      end
      `SL_REG_ISOLATED:   prdata_o[1:0] = isolated_i;
      `SL_REG_CLK_DIV:    prdata_o[`SL_CLK_DIV_W-1:0] = clk_div_o;
      `SL_REG_RAW_OUT_EN: prdata_o[0] = raw_out_en_o;
      `SL_REG_RAW_OUT_CTRL: begin
        prdata_o[FillW-1:0] = tx_fill_i;
        prdata_o[8]         = tx_full_i;
      end
      // Head word only when valid, otherwise all zero
      `SL_REG_RAW_IN_DATA: begin
        if (rx_not_empty_i) begin
          prdata_o[DataW-1:0] = rx_data_i;
          prdata_o[31]        = 1'b1;
        end
      end
      default: prdata_o = '0;
    endcase
  end

endmodule

// ==== design/serial_link_fifo.sv ====
`include "serial_link_cfg.svh"

module serial_link_fifo (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  serial_link_pkg::phy_data_t data_i,
  input  logic                       pop_i,
  output serial_link_pkg::phy_data_t data_o,
  output logic                       not_empty_o,
  output logic                       full_o,
  output serial_link_pkg::fill_t     fill_o
);

  localparam int unsigned Depth = `SL_FIFO_DEPTH;
  localparam int unsigned PtrW = $clog2(Depth);

  serial_link_pkg::phy_data_t mem_q [Depth];
  logic [PtrW-1:0]            wr_ptr_q;
  logic [PtrW-1:0]            rd_ptr_q;
  serial_link_pkg::fill_t     count_q;
  logic                       do_push;
  logic                       do_pop;

  assign full_o      = (count_q == serial_link_pkg::fill_t'(Depth));
  assign not_empty_o = (count_q != '0);
  assign fill_o      = count_q;
  assign data_o      = mem_q[rd_ptr_q];

  // Push to a full or pop from an empty FIFO has no effect
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & not_empty_o;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== design/serial_link_pkg.sv ====
`include "serial_link_cfg.svh"

package serial_link_pkg;

  // Word seen on the lanes at one forwarded clock edge
  typedef logic [`SL_NUM_LANES-1:0] lane_t;

  // Raw word, low lane word first and high lane word second
  typedef logic [2*`SL_NUM_LANES-1:0] phy_data_t;

  typedef logic [`SL_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Clock cycles per forwarded clock phase
  typedef logic [`SL_CLK_DIV_W-1:0] clk_div_t;

  // One extra bit so a full FIFO can report its whole depth
  typedef logic [$clog2(`SL_FIFO_DEPTH):0] fill_t;

  // Four phases per word, the forwarded clock is high in the two hold phases
  typedef enum logic [2:0] {
    TX_IDLE       = 3'd0,
    TX_LOW_SETUP  = 3'd1,
    TX_LOW_HOLD   = 3'd2,
    TX_HIGH_HOLD  = 3'd3,
    TX_HIGH_SETUP = 3'd4
  } tx_state_e;

endpackage

// ==== design/serial_link_cfg.svh ====
`ifndef SERIAL_LINK_CFG_SVH
`define SERIAL_LINK_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Link geometry
//////////////////////////////////////////////////////////////////////

// Lanes driven in parallel, two lane words per forwarded clock period
`define SL_NUM_LANES 8
// Depth of the raw TX FIFO and of the RX FIFO, a power of two
`define SL_FIFO_DEPTH 8
`define SL_APB_ADDR_W 8
`define SL_CLK_DIV_W 8

//////////////////////////////////////////////////////////////////////
// Register offsets
//////////////////////////////////////////////////////////////////////

`define SL_REG_CTRL 8'h00
`define SL_REG_ISOLATED 8'h04
`define SL_REG_CLK_DIV 8'h08
`define SL_REG_RAW_OUT_EN 8'h0C
`define SL_REG_RAW_OUT_DATA 8'h10
`define SL_REG_RAW_OUT_CTRL 8'h14
`define SL_REG_RAW_IN_DATA 8'h18

`endif
